//--- src/huffman_pkg.sv
package huffman_pkg;

	// datapath widths
	localparam int SAMPLE_W = 8;
	localparam int COUNT_W = 8;  // also the width of merged group weights
	localparam int CODE_W = 8;
	localparam int LEN_W = 3;

	// upper bound on the symbol alphabet, fixes the index width
	localparam int MAX_SYMBOLS = 8;

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [COUNT_W-1:0] count_t;
	typedef logic [CODE_W-1:0] code_t;  // code word or length mask
	typedef logic [LEN_W-1:0] len_t;
	typedef logic [$clog2(MAX_SYMBOLS)-1:0] sym_id_t;

endpackage

//--- src/huffman_ctrl.sv
`timescale 1ns/100ps

module huffman_ctrl #(
	parameter int NUM_SYMBOLS = 6
) (
	input logic clk,
	input logic reset,
	input logic gray_valid,
	output logic frame_start,
	output logic counting,
	output logic load_slots,
	output logic sort_pass,
	output logic pass_odd,
	output logic merge,
	output logic [$bits(huffman_pkg::sym_id_t):0] active,
	output logic cnt_valid,
	output logic code_valid
);

	import huffman_pkg::*;

	typedef logic [$bits(sym_id_t):0] act_t;

	typedef enum logic [2:0] {
		st_idle,
		st_count,
		st_report,
		st_sort,
		st_merge,
		st_publish
	} state_t;

	state_t state;
	state_t state_nx;
	act_t pass_cnt;  // sort passes done in this phase

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			state <= st_idle;
		else
			state <= state_nx;
	end

	always_comb begin
		state_nx = state;
		case (state)
			st_idle:
				if (gray_valid)
					state_nx = st_count;
			st_count:
				if (!gray_valid)
					state_nx = st_report;
			st_report:
				state_nx = st_sort;
			st_sort:
				if (pass_cnt == active - 1'b1)  // one pass per live group
					state_nx = st_merge;
			st_merge:
				if (active == act_t'(2))
					state_nx = st_publish;  // last merge leaves one group
				else
					state_nx = st_sort;
			st_publish:
				state_nx = st_idle;
			default:
				state_nx = st_idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pass_cnt <= '0;
		else if (state == st_sort)
			pass_cnt <= pass_cnt + 1'b1;
		else
			pass_cnt <= '0;
	end

	// live groups, back to full size once the tree is done
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active <= act_t'(NUM_SYMBOLS);
		end else if (state == st_merge) begin
			if (active == act_t'(2))
				active <= act_t'(NUM_SYMBOLS);
			else
				active <= active - 1'b1;
		end
	end

	assign frame_start = (state == st_idle) && gray_valid;
	assign counting = (state == st_count);
	assign load_slots = (state == st_report);
	assign cnt_valid = (state == st_report);
	assign sort_pass = (state == st_sort);
	assign pass_odd = pass_cnt[0];  // even pairs on the first pass
	assign merge = (state == st_merge);
	assign code_valid = (state == st_publish);

endmodule

//--- src/symbol_histogram.sv
`timescale 1ns/100ps

module symbol_histogram #(
	parameter int NUM_SYMBOLS = 6,
	parameter huffman_pkg::sample_t FIRST_SYMBOL = 8'h01
) (
	input logic clk,
	input logic reset,
	input logic frame_start,
	input logic counting,
	input logic gray_valid,
	input huffman_pkg::sample_t gray_data,
	input logic cnt_valid,
	output huffman_pkg::count_t counts [NUM_SYMBOLS],
	output huffman_pkg::count_t cnt [NUM_SYMBOLS]
);

	import huffman_pkg::*;

	count_t counter [NUM_SYMBOLS];
	logic [NUM_SYMBOLS-1:0] hit;  // one-hot, zero for bytes out of range

	always_comb begin
		for (int s = 0; s < NUM_SYMBOLS; s++) begin
			hit[s] = gray_valid && (gray_data == sample_t'(FIRST_SYMBOL + s));
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < NUM_SYMBOLS; s++)
				counter[s] <= '0;
		end else if (frame_start) begin
			// first sample of a burst restarts every counter
			for (int s = 0; s < NUM_SYMBOLS; s++)
				counter[s] <= count_t'(hit[s]);
		end else if (counting) begin
			for (int s = 0; s < NUM_SYMBOLS; s++)
				counter[s] <= counter[s] + count_t'(hit[s]);
		end
	end

	always_comb begin
		for (int s = 0; s < NUM_SYMBOLS; s++) begin
			counts[s] = counter[s];
			cnt[s] = cnt_valid ? counter[s] : '0;
		end
	end

endmodule

//--- src/group_sorter.sv
`timescale 1ns/100ps

module group_sorter #(
	parameter int NUM_SYMBOLS = 6
) (
	input logic clk,
	input logic reset,
	input logic load_slots,
	input huffman_pkg::count_t counts [NUM_SYMBOLS],
	input logic sort_pass,
	input logic pass_odd,
	input logic merge,
	input logic [$bits(huffman_pkg::sym_id_t):0] active,
	output logic [NUM_SYMBOLS-1:0] low_members,
	output logic [NUM_SYMBOLS-1:0] high_members
);

	import huffman_pkg::*;

	typedef logic [NUM_SYMBOLS-1:0] member_t;

	count_t weight [NUM_SYMBOLS];
	sym_id_t leader [NUM_SYMBOLS];
	member_t members [NUM_SYMBOLS];

	logic [NUM_SYMBOLS-2:0] swap;  // one flag per neighbour pair
	sym_id_t lo_idx;
	sym_id_t hi_idx;

	// heavier first, lower leader wins a tie
	function automatic logic outranks(
		input count_t w_a,
		input sym_id_t l_a,
		input count_t w_b,
		input sym_id_t l_b
	);
		return (w_a > w_b) || ((w_a == w_b) && (l_a < l_b));
	endfunction

	// only pairs of the current phase that lie fully in the live range
	always_comb begin
		for (int i = 0; i < NUM_SYMBOLS - 1; i++) begin
			swap[i] = (i[0] == pass_odd) && (i + 1 < int'(active)) &&
				outranks(weight[i + 1], leader[i + 1], weight[i], leader[i]);
		end
	end

	assign lo_idx = sym_id_t'(active - 1);
	assign hi_idx = sym_id_t'(active - 2);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int j = 0; j < NUM_SYMBOLS; j++) begin
				weight[j] <= '0;
				leader[j] <= sym_id_t'(j);
				members[j] <= member_t'(1) << j;
			end
		end else if (load_slots) begin
			// slot j starts as symbol j alone
			for (int j = 0; j < NUM_SYMBOLS; j++) begin
				weight[j] <= counts[j];
				leader[j] <= sym_id_t'(j);
				members[j] <= member_t'(1) << j;
			end
		end else if (sort_pass) begin
			for (int i = 0; i < NUM_SYMBOLS - 1; i++) begin
				if (swap[i]) begin
					weight[i] <= weight[i + 1];
					weight[i + 1] <= weight[i];
					leader[i] <= leader[i + 1];
					leader[i + 1] <= leader[i];
					members[i] <= members[i + 1];
					members[i + 1] <= members[i];
				end
			end
		end else if (merge) begin
			// lowest slot folds into the next one, which keeps its leader
			weight[hi_idx] <= weight[hi_idx] + weight[lo_idx];
			members[hi_idx] <= members[hi_idx] | members[lo_idx];
		end
	end

	assign low_members = members[lo_idx];
	assign high_members = members[hi_idx];

endmodule

//--- src/code_table.sv
`timescale 1ns/100ps

module code_table #(
	parameter int NUM_SYMBOLS = 6
) (
	input logic clk,
	input logic reset,
	input logic frame_start,
	input logic merge,
	input logic [NUM_SYMBOLS-1:0] low_members,
	input logic [NUM_SYMBOLS-1:0] high_members,
	input logic code_valid,
	output huffman_pkg::code_t hc [NUM_SYMBOLS],
	output huffman_pkg::code_t m [NUM_SYMBOLS]
);

	import huffman_pkg::*;

	code_t code_bits [NUM_SYMBOLS];
	code_t mask [NUM_SYMBOLS];
	len_t code_len [NUM_SYMBOLS];  // next free bit position

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < NUM_SYMBOLS; s++) begin
				code_bits[s] <= '0;
				mask[s] <= '0;
				code_len[s] <= '0;
			end
		end else if (frame_start) begin
			for (int s = 0; s < NUM_SYMBOLS; s++) begin
				code_bits[s] <= '0;
				mask[s] <= '0;
				code_len[s] <= '0;
			end
		end else if (merge) begin
			// bits are filled from the leaf upward, root bit ends on top
			for (int s = 0; s < NUM_SYMBOLS; s++) begin
				if (low_members[s] || high_members[s]) begin
					code_bits[s][code_len[s]] <= low_members[s];  // 1 for low side
					code_len[s] <= code_len[s] + 1'b1;
					mask[s] <= (mask[s] << 1) | code_t'(1);
				end
			end
		end
	end

	always_comb begin
		for (int s = 0; s < NUM_SYMBOLS; s++) begin
			hc[s] = code_valid ? code_bits[s] : '0;
			m[s] = code_valid ? mask[s] : '0;
		end
	end

endmodule

//--- src/huffman_top.sv
`timescale 1ns/100ps

module huffman_top #(
	parameter int NUM_SYMBOLS = 6,
	parameter huffman_pkg::sample_t FIRST_SYMBOL = 8'h01
) (
	input logic clk,
	input logic reset,
	input logic gray_valid,
	input huffman_pkg::sample_t gray_data,
	output logic cnt_valid,
	output huffman_pkg::count_t cnt [NUM_SYMBOLS],
	output logic code_valid,
	output huffman_pkg::code_t hc [NUM_SYMBOLS],
	output huffman_pkg::code_t m [NUM_SYMBOLS]
);

	import huffman_pkg::*;

	logic frame_start;
	logic counting;
	logic load_slots;
	logic sort_pass;
	logic pass_odd;
	logic merge;
	logic [$bits(sym_id_t):0] active;
	count_t counts [NUM_SYMBOLS];  // raw counters into the sorter
	logic [NUM_SYMBOLS-1:0] low_members;
	logic [NUM_SYMBOLS-1:0] high_members;

	huffman_ctrl #(
		.NUM_SYMBOLS(NUM_SYMBOLS)
	) u_ctrl (
		.clk(clk),
		.reset(reset),
		.gray_valid(gray_valid),
		.frame_start(frame_start),
		.counting(counting),
		.load_slots(load_slots),
		.sort_pass(sort_pass),
		.pass_odd(pass_odd),
		.merge(merge),
		.active(active),
		.cnt_valid(cnt_valid),
		.code_valid(code_valid)
	);

	symbol_histogram #(
		.NUM_SYMBOLS(NUM_SYMBOLS),
		.FIRST_SYMBOL(FIRST_SYMBOL)
	) u_histogram (
		.clk(clk),
		.reset(reset),
		.frame_start(frame_start),
		.counting(counting),
		.gray_valid(gray_valid),
		.gray_data(gray_data),
		.cnt_valid(cnt_valid),
		.counts(counts),
		.cnt(cnt)
	);

	group_sorter #(
		.NUM_SYMBOLS(NUM_SYMBOLS)
	) u_sorter (
		.clk(clk),
		.reset(reset),
		.load_slots(load_slots),
		.counts(counts),
		.sort_pass(sort_pass),
		.pass_odd(pass_odd),
		.merge(merge),
		.active(active),
		.low_members(low_members),
		.high_members(high_members)
	);

	code_table #(
		.NUM_SYMBOLS(NUM_SYMBOLS)
	) u_code_table (
		.clk(clk),
		.reset(reset),
		.frame_start(frame_start),
		.merge(merge),
		.low_members(low_members),
		.high_members(high_members),
		.code_valid(code_valid),
		.hc(hc),
		.m(m)
	);

endmodule

//--- include/huffman_model.svh
`ifndef HUFFMAN_MODEL_SVH
`define HUFFMAN_MODEL_SVH

localparam int MODEL_SYMBOLS = 6;
localparam int MODEL_FIRST = 8'h01;  // byte value of symbol 0

typedef huffman_pkg::count_t model_count_t [MODEL_SYMBOLS];
typedef huffman_pkg::code_t model_code_t [MODEL_SYMBOLS];

// counts only the bytes in range
function automatic model_count_t count_symbols(input huffman_pkg::sample_t samples [$]);
	model_count_t counts;
	int idx;
	foreach (counts[s])
		counts[s] = '0;
	foreach (samples[k]) begin
		idx = int'(samples[k]) - MODEL_FIRST;
		if (idx >= 0 && idx < MODEL_SYMBOLS)
			counts[idx]++;
	end
	return counts;
endfunction

// heavier first and lower leader on a tie
function automatic bit ranks_higher(input int w_a, input int l_a, input int w_b,
	input int l_b);
	return (w_a > w_b) || ((w_a == w_b) && (l_a < l_b));
endfunction

// code words and masks with bit 0 at the leaf end
function automatic void build_codes(input model_count_t counts, output model_code_t hc,
	output model_code_t m);
	int weight [MODEL_SYMBOLS];
	int leader [MODEL_SYMBOLS];
	bit [MODEL_SYMBOLS-1:0] members [MODEL_SYMBOLS];
	int len [MODEL_SYMBOLS];
	int tmp_w;
	int tmp_l;
	bit [MODEL_SYMBOLS-1:0] tmp_m;
	for (int j = 0; j < MODEL_SYMBOLS; j++) begin
		weight[j] = counts[j];
		leader[j] = j;
		members[j] = 1 << j;
		len[j] = 0;
		hc[j] = '0;
	end
	for (int active = MODEL_SYMBOLS; active > 1; active--) begin
		// bubble sort of the live slots
		for (int p = 0; p < active; p++) begin
			for (int i = 0; i < active - 1; i++) begin
				if (ranks_higher(weight[i + 1], leader[i + 1], weight[i], leader[i])) begin
					tmp_w = weight[i];
					tmp_l = leader[i];
					tmp_m = members[i];
					weight[i] = weight[i + 1];
					leader[i] = leader[i + 1];
					members[i] = members[i + 1];
					weight[i + 1] = tmp_w;
					leader[i + 1] = tmp_l;
					members[i + 1] = tmp_m;
				end
			end
		end
		for (int s = 0; s < MODEL_SYMBOLS; s++) begin
			if (members[active - 1][s] || members[active - 2][s]) begin
				hc[s][len[s]] = members[active - 1][s];
				len[s]++;
			end
		end
		weight[active - 2] += weight[active - 1];
		members[active - 2] |= members[active - 1];
	end
	for (int s = 0; s < MODEL_SYMBOLS; s++)
		m[s] = huffman_pkg::code_t'((1 << len[s]) - 1);  // one mask bit per code bit
endfunction

`endif

//--- testbench/huffman_tb.sv
`timescale 1ns/100ps

module huffman_tb;

	import huffman_pkg::*;

	`include "huffman_model.svh"

	localparam int NUM_FRAMES = 6;
	localparam int CNT_TIMEOUT = 8;
	localparam int CODE_TIMEOUT = 100;

	// six target counts per frame
	int target [NUM_FRAMES][MODEL_SYMBOLS] = '{
		'{1, 2, 4, 8, 16, 32},
		'{5, 5, 5, 5, 5, 5},
		'{0, 3, 0, 7, 0, 1},
		'{12, 3, 3, 20, 7, 12},
		'{0, 0, 9, 0, 0, 0},
		'{40, 1, 1, 2, 90, 40}
	};
	int junk_bytes [NUM_FRAMES] = '{0, 6, 10, 4, 3, 20};  // out-of-range bytes
	bit busy_pulses [NUM_FRAMES] = '{0, 1, 0, 1, 0, 1};  // gray_valid pulses while busy

	logic clk;
	logic reset;
	logic gray_valid;
	sample_t gray_data;
	logic cnt_valid;
	count_t cnt [MODEL_SYMBOLS];
	logic code_valid;
	code_t hc [MODEL_SYMBOLS];
	code_t m [MODEL_SYMBOLS];

	logic [31:0] lfsr;
	int errors;
	int checks;
	int cnt_pulses;
	int code_pulses;
	int frames_done;
	bit timed_out;
	sample_t samples [$];  // current burst in send order

	huffman_top #(
		.NUM_SYMBOLS(MODEL_SYMBOLS),
		.FIRST_SYMBOL(8'h01)
	) dut (
		.clk(clk),
		.reset(reset),
		.gray_valid(gray_valid),
		.gray_data(gray_data),
		.cnt_valid(cnt_valid),
		.cnt(cnt),
		.code_valid(code_valid),
		.hc(hc),
		.m(m)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic int random_bits(input int n);
		logic fb;
		int value;
		value = 0;
		for (int b = 0; b < n; b++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			value = (value << 1) | int'(fb);
		end
		return value;
	endfunction

	task automatic build_frame(input int f);
		int r;
		int j;
		sample_t tmp;
		samples.delete();
		for (int s = 0; s < MODEL_SYMBOLS; s++) begin
			for (int k = 0; k < target[f][s]; k++)
				samples.push_back(sample_t'(MODEL_FIRST + s));
		end
		for (int k = 0; k < junk_bytes[f]; k++) begin
			if (k < 2)
				r = k;  // bytes just below and just above the symbol range
			else
				r = random_bits(8) % 250;
			// 0 maps to 8'h00 and the rest to 8'h07..8'hff
			samples.push_back(sample_t'(r == 0 ? 0 : r + 6));
		end
		// fisher-yates shuffle
		for (int k = samples.size() - 1; k > 0; k--) begin
			r = random_bits(8);
			j = r % (k + 1);
			tmp = samples[k];
			samples[k] = samples[j];
			samples[j] = tmp;
		end
	endtask

	task automatic check_value(input string name, input int idx, input logic [7:0] expected,
		input logic [7:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s[%0d] expected %h got %h", name, idx, expected, actual);
		end
	endtask

	// masks run from bit 0 and codes are prefix free
	task automatic verify_code_shape();
		int bits_s;
		int bits_t;
		for (int s = 0; s < MODEL_SYMBOLS; s++) begin
			checks++;
			if (m[s] == 0 || (m[s] & (m[s] + 1'b1)) != 0) begin
				errors++;
				$display("mask of symbol %0d is not a run of ones from bit 0", s);
			end
		end
		for (int s = 0; s < MODEL_SYMBOLS; s++) begin
			for (int t = 0; t < MODEL_SYMBOLS; t++) begin
				bits_s = $countones(m[s]);
				bits_t = $countones(m[t]);
				checks++;
				if (s != t && bits_s <= bits_t && (hc[t] >> (bits_t - bits_s)) == hc[s]) begin
					errors++;
					$display("code of symbol %0d is a prefix of the code of symbol %0d", s, t);
				end
			end
		end
	endtask

	task automatic run_frame(input int f);
		model_count_t exp_counts;
		model_code_t exp_hc;
		model_code_t exp_m;
		int waited;
		int b;
		int v;
		int start_errors;
		start_errors = errors;
		build_frame(f);
		exp_counts = count_symbols(samples);
		build_codes(exp_counts, exp_hc, exp_m);
		checks++;
		if (cnt_pulses != f || code_pulses != f) begin
			errors++;
			$display("frame %0d started after %0d cnt_valid and %0d code_valid pulses",
				f, cnt_pulses, code_pulses);
		end
		foreach (samples[k]) begin
			gray_valid = 1'b1;
			gray_data = samples[k];
			@(posedge clk);
			#10;
		end
		gray_valid = 1'b0;
		gray_data = '0;
		waited = 0;
		while (waited < CNT_TIMEOUT) begin
			@(negedge clk);
			waited++;
			if (cnt_valid)
				break;
		end
		if (!cnt_valid) begin
			$display("timeout waiting for cnt_valid");
			timed_out = 1'b1;
			return;
		end
		checks++;
		if (waited != 2) begin
			errors++;
			$display("cnt_valid came %0d cycles after the burst, expected 2", waited);
		end
		for (int s = 0; s < MODEL_SYMBOLS; s++)
			check_value("cnt", s, 8'(target[f][s]), cnt[s]);
		waited = 0;
		while (!code_valid && waited < CODE_TIMEOUT) begin
			@(posedge clk);
			#10;
			if (busy_pulses[f]) begin  // in-range samples the coder must ignore
				b = random_bits(1);
				v = random_bits(3);
				gray_valid = b[0];
				gray_data = sample_t'(MODEL_FIRST + v % MODEL_SYMBOLS);
			end
			@(negedge clk);
			waited++;
		end
		if (!code_valid) begin
			$display("timeout waiting for code_valid");
			timed_out = 1'b1;
			return;
		end
		for (int s = 0; s < MODEL_SYMBOLS; s++) begin
			check_value("hc", s, exp_hc[s], hc[s]);
			check_value("m", s, exp_m[s], m[s]);
		end
		verify_code_shape();
		@(posedge clk);
		#10;
		gray_valid = 1'b0;
		gray_data = '0;
		repeat (3) @(posedge clk);
		#10;
		checks++;
		if (cnt_pulses != f + 1 || code_pulses != f + 1) begin
			errors++;
			$display("frame %0d gave %0d cnt_valid and %0d code_valid pulses in total",
				f, cnt_pulses, code_pulses);
		end
		frames_done++;
		$display("frame %0d done, %0d errors", f, errors - start_errors);
	endtask

	// outputs stay zero outside their valid pulses
	always @(negedge clk) begin
		if (cnt_valid)
			cnt_pulses++;
		if (code_valid)
			code_pulses++;
		for (int s = 0; s < MODEL_SYMBOLS; s++) begin
			if (!cnt_valid && cnt[s] !== '0) begin
				errors++;
				$display("[ERROR] cnt[%0d] expected %h got %h", s, 8'h00, cnt[s]);
			end
			if (!code_valid && hc[s] !== '0) begin
				errors++;
				$display("[ERROR] hc[%0d] expected %h got %h", s, 8'h00, hc[s]);
			end
			if (!code_valid && m[s] !== '0) begin
				errors++;
				$display("[ERROR] m[%0d] expected %h got %h", s, 8'h00, m[s]);
			end
		end
		if (reset && (cnt_valid || code_valid)) begin
			errors++;
			$display("a valid output was high during reset");
		end
	end

	initial begin
		lfsr = 32'h70457818;
		errors = 0;
		checks = 0;
		cnt_pulses = 0;
		code_pulses = 0;
		frames_done = 0;
		timed_out = 1'b0;
		reset = 1'b1;
		gray_valid = 1'b0;
		gray_data = '0;
		repeat (10) @(posedge clk);
		#10;
		reset = 1'b0;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			run_frame(f);
			if (timed_out)
				break;
		end
		$display("%0d frames, %0d checks, %0d errors", frames_done, checks, errors);
		if (errors == 0 && !timed_out)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- sources.f
+incdir+include
src/huffman_pkg.sv
src/huffman_ctrl.sv
src/symbol_histogram.sv
src/group_sorter.sv
src/code_table.sv
src/huffman_top.sv
testbench/huffman_tb.sv
